/* src/apu_consts.svh */
// APU audio block constants
// Widths, peripheral address map, register offsets and CSR field positions

`ifndef APU_CONSTS_SVH
`define APU_CONSTS_SVH

// Datapath widths
`define APU_W_DATA            32
`define APU_W_ADDR            16
`define APU_W_SAMPLE          16
`define APU_FIFO_W_ADDR       2
`define APU_PWM_BITS          8

// 4 kB peripheral windows
`define APU_AOUT_BASE         16'ha000
`define APU_TIMER_BASE        16'hb000
`define APU_WINDOW_MASK       16'hf000

// AOUT register offsets
`define APU_AOUT_CSR          16'h0000
`define APU_AOUT_FIFO         16'h0004

// Timer register offsets
`define APU_TIMER_CTRL        16'h0000
`define APU_TIMER_COUNT       16'h0004
`define APU_TIMER_CMP         16'h0008
`define APU_TIMER_EN_BIT      0

// AOUT CSR fields
`define APU_CSR_ENABLE_BIT    0
`define APU_CSR_SIGNED_BIT    1
`define APU_CSR_RUNNING_BIT   2
`define APU_CSR_RDY_BIT       3
`define APU_CSR_FLEVEL_LSB    8
`define APU_CSR_FLEVEL_MSB    10
`define APU_CSR_IRQLEVEL_LSB  16
`define APU_CSR_IRQLEVEL_MSB  18
`define APU_CSR_INTERVAL_LSB  24
`define APU_CSR_INTERVAL_MSB  31

`endif

/* src/apu_pkg.sv */
// APU audio block shared types
// Bus, sample and PWM types used across the peripherals

`include "apu_consts.svh"

package apu_pkg;

    // Bus side
    typedef logic [`APU_W_DATA-1:0] bus_word_t;
    typedef logic [`APU_W_ADDR-1:0] bus_addr_t;
    typedef logic [1:0]             htrans_t;

    // Audio samples and FIFO occupancy (0 to depth inclusive)
    typedef logic [`APU_W_SAMPLE-1:0]  sample_t;
    typedef logic [`APU_FIFO_W_ADDR:0] fifo_level_t;

    // PWM duty and per-sample repeat count
    typedef logic [`APU_PWM_BITS-1:0] pwm_duty_t;
    typedef logic [`APU_CSR_INTERVAL_MSB-`APU_CSR_INTERVAL_LSB:0] interval_t;

    // PWM generator states
    typedef enum logic [0:0] {
        PWM_IDLE,
        PWM_PLAY
    } pwm_state_e;

endpackage

/* src/apu_sample_fifo.sv */
// Four-entry synchronous sample FIFO
// First-word-fall-through read port with occupancy count

`include "apu_consts.svh"

module apu_sample_fifo import apu_pkg::*; (
    input  logic        clk_sys,
    input  logic        rst_n_sram,
    input  logic        push,
    input  logic        pop,
    input  sample_t     wdata,
    output sample_t     rdata,
    output logic        full,
    output logic        empty,
    output fifo_level_t level
);

    localparam fifo_level_t DEPTH = fifo_level_t'(1 << `APU_FIFO_W_ADDR);

    sample_t                     mem [1 << `APU_FIFO_W_ADDR];
    logic [`APU_FIFO_W_ADDR-1:0] wptr;
    logic [`APU_FIFO_W_ADDR-1:0] rptr;
    logic                        do_push;
    logic                        do_pop;

    assign full    = level == DEPTH;
    assign empty   = level == '0;
    // Push to a full FIFO is lost
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk_sys or negedge rst_n_sram) begin
        if (!rst_n_sram) begin
            wptr  <= '0;
            rptr  <= '0;
            level <= '0;
        end else begin
            if (do_push) begin
                wptr <= wptr + 1'b1;
            end
            if (do_pop) begin
                rptr <= rptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                level <= level + 1'b1;
            end else if (do_pop && !do_push) begin
                level <= level - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (do_push) begin
            mem[wptr] <= wdata;
        end
    end

    assign rdata = mem[rptr];

endmodule

/* src/apu_pwm_out.sv */
// PWM audio output stage
// Plays each FIFO sample for interval+1 periods of 256 cycles

`include "apu_consts.svh"

module apu_pwm_out import apu_pkg::*; (
    input  logic      clk_sys,
    input  logic      rst_n_sram,
    input  logic      en,
    input  interval_t interval,
    input  sample_t   sample,
    input  logic      empty,
    output logic      pop,
    output logic      running,
    output logic      pwm
);

    localparam pwm_duty_t MIDSCALE = pwm_duty_t'(1 << (`APU_PWM_BITS - 1));

    pwm_state_e state;
    pwm_duty_t  period_ctr;
    interval_t  repeat_left;
    pwm_duty_t  duty;
    pwm_duty_t  next_duty;
    logic       period_end;
    logic       boundary;

    // Top bits of the signed sample, offset to binary
    assign next_duty  = sample[`APU_W_SAMPLE-1 -: `APU_PWM_BITS] ^ MIDSCALE;
    assign period_end = period_ctr == '1;
    assign boundary   = state == PWM_PLAY && period_end && en && repeat_left == '0;

    assign pop     = !empty && ((state == PWM_IDLE && en) || boundary);
    assign running = state == PWM_PLAY;
    assign pwm     = running && period_ctr < duty;

    always_ff @(posedge clk_sys or negedge rst_n_sram) begin
        if (!rst_n_sram) begin
            state       <= PWM_IDLE;
            period_ctr  <= '0;
            repeat_left <= '0;
            duty        <= MIDSCALE;
        end else begin
            case (state)
                PWM_IDLE: begin
                    if (en) begin
                        state       <= PWM_PLAY;
                        period_ctr  <= '0;
                        repeat_left <= interval;
                        duty        <= empty ? MIDSCALE : next_duty;
                    end
                end
                PWM_PLAY: begin
                    period_ctr <= period_ctr + 1'b1;
                    if (period_end) begin
                        // Stop only at the end of a whole period
                        if (!en) begin
                            state <= PWM_IDLE;
                        end else if (repeat_left == '0) begin
                            repeat_left <= interval;
                            // Underrun holds the previous duty
                            if (!empty) begin
                                duty <= next_duty;
                            end
                        end else begin
                            repeat_left <= repeat_left - 1'b1;
                        end
                    end
                end
                default: state <= PWM_IDLE;
            endcase
        end
    end

endmodule

/* src/apu_aout.sv */
// AOUT peripheral
// CSR and sample FIFO registers, level interrupt, FIFO and PWM output stage

`include "apu_consts.svh"

module apu_aout import apu_pkg::*; (
    input  logic      clk_sys,
    input  logic      rst_n_sram,
    input  bus_addr_t reg_addr,
    input  logic      wen,
    input  bus_word_t wdata,
    output bus_word_t rdata,
    output logic      audio,
    output logic      irq
);

    logic        enable;
    logic        csr_signed;
    fifo_level_t irqlevel;
    interval_t   interval;
    logic        running;

    logic        push;
    sample_t     push_data;
    logic        pop;
    sample_t     fifo_rdata;
    logic        fifo_full;
    logic        fifo_empty;
    fifo_level_t fifo_level;

    // ----------------------------------------------------------------------
    // Registers

    always_ff @(posedge clk_sys or negedge rst_n_sram) begin
        if (!rst_n_sram) begin
            enable     <= 1'b0;
            csr_signed <= 1'b0;
            irqlevel   <= '0;
            interval   <= '0;
        end else if (wen && reg_addr == `APU_AOUT_CSR) begin
            enable     <= wdata[`APU_CSR_ENABLE_BIT];
            csr_signed <= wdata[`APU_CSR_SIGNED_BIT];
            irqlevel   <= wdata[`APU_CSR_IRQLEVEL_MSB:`APU_CSR_IRQLEVEL_LSB];
            interval   <= wdata[`APU_CSR_INTERVAL_MSB:`APU_CSR_INTERVAL_LSB];
        end
    end

    always_comb begin
        rdata = '0;
        if (reg_addr == `APU_AOUT_CSR) begin
            rdata[`APU_CSR_ENABLE_BIT]  = enable;
            rdata[`APU_CSR_SIGNED_BIT]  = csr_signed;
            rdata[`APU_CSR_RUNNING_BIT] = running;
            rdata[`APU_CSR_RDY_BIT]     = !fifo_full;
            rdata[`APU_CSR_FLEVEL_MSB:`APU_CSR_FLEVEL_LSB]     = fifo_level;
            rdata[`APU_CSR_IRQLEVEL_MSB:`APU_CSR_IRQLEVEL_LSB] = irqlevel;
            rdata[`APU_CSR_INTERVAL_MSB:`APU_CSR_INTERVAL_LSB] = interval;
        end
    end

    // Unsigned input is moved to two's complement by flipping the MSB
    assign push      = wen && reg_addr == `APU_AOUT_FIFO;
    assign push_data = wdata[`APU_W_SAMPLE-1:0] ^ {!csr_signed, {(`APU_W_SAMPLE-1){1'b0}}};

    assign irq = fifo_level <= irqlevel;

    // ----------------------------------------------------------------------
    // Sample FIFO and PWM

    apu_sample_fifo fifo_u (
        .clk_sys (clk_sys), .rst_n_sram (rst_n_sram),
        .push    (push),    .pop        (pop),
        .wdata   (push_data), .rdata    (fifo_rdata),
        .full    (fifo_full), .empty    (fifo_empty),
        .level   (fifo_level)
    );

    apu_pwm_out pwm_u (
        .clk_sys  (clk_sys),    .rst_n_sram (rst_n_sram),
        .en       (enable),     .interval   (interval),
        .sample   (fifo_rdata), .empty      (fifo_empty),
        .pop      (pop),        .running    (running),
        .pwm      (audio)
    );

endmodule

/* src/apu_timer.sv */
// APU compare timer
// Free-running 32-bit counter with compare register and level interrupt

`include "apu_consts.svh"

module apu_timer import apu_pkg::*; (
    input  logic      clk_sys,
    input  logic      rst_n_sram,
    input  bus_addr_t reg_addr,
    input  logic      wen,
    input  bus_word_t wdata,
    output bus_word_t rdata,
    output logic      irq
);

    logic      enable;
    bus_word_t count;
    bus_word_t compare;
    logic      wr_ctrl;
    logic      wr_count;
    logic      wr_cmp;

    assign wr_ctrl  = wen && reg_addr == `APU_TIMER_CTRL;
    assign wr_count = wen && reg_addr == `APU_TIMER_COUNT;
    assign wr_cmp   = wen && reg_addr == `APU_TIMER_CMP;

    always_ff @(posedge clk_sys or negedge rst_n_sram) begin
        if (!rst_n_sram) begin
            enable  <= 1'b0;
            count   <= '0;
            compare <= '1;
        end else begin
            if (wr_ctrl) begin
                enable <= wdata[`APU_TIMER_EN_BIT];
            end
            if (wr_cmp) begin
                compare <= wdata;
            end
            // Software write wins over the increment
            if (wr_count) begin
                count <= wdata;
            end else if (enable) begin
                count <= count + 1'b1;
            end
        end
    end

    always_comb begin
        rdata = '0;
        case (reg_addr)
            `APU_TIMER_CTRL:  rdata[`APU_TIMER_EN_BIT] = enable;
            `APU_TIMER_COUNT: rdata = count;
            `APU_TIMER_CMP:   rdata = compare;
            default:          rdata = '0;
        endcase
    end

    assign irq = enable && count >= compare;

endmodule

/* src/apu_ahbl_port.sv */
// AHB-Lite slave port for the APU peripherals
// Captures the address phase, decodes the windows and drives data-phase strobes

`include "apu_consts.svh"

module apu_ahbl_port import apu_pkg::*; (
    input  logic      clk_sys,
    input  logic      rst_n_sram,

    input  bus_addr_t haddr,
    input  logic      hwrite,
    input  htrans_t   htrans,
    input  logic      hready,
    output bus_word_t hrdata,

    output bus_addr_t reg_addr,
    output logic      aout_wen,
    output logic      timer_wen,
    input  bus_word_t aout_rdata,
    input  bus_word_t timer_rdata
);

    logic accept;
    logic hit_aout;
    logic hit_timer;
    logic aout_sel;
    logic timer_sel;
    logic dphase_write;

    // NONSEQ or SEQ with the bus ready
    assign accept    = hready && htrans[1];
    assign hit_aout  = (haddr & `APU_WINDOW_MASK) == `APU_AOUT_BASE;
    assign hit_timer = (haddr & `APU_WINDOW_MASK) == `APU_TIMER_BASE;

    // ----------------------------------------------------------------------
    // Address phase capture

    always_ff @(posedge clk_sys or negedge rst_n_sram) begin
        if (!rst_n_sram) begin
            aout_sel     <= 1'b0;
            timer_sel    <= 1'b0;
            dphase_write <= 1'b0;
        end else begin
            // Slave never stalls so every data phase lasts exactly one cycle
            aout_sel     <= accept && hit_aout;
            timer_sel    <= accept && hit_timer;
            dphase_write <= accept && hwrite;
        end
    end

    // Word offset within the window
    always_ff @(posedge clk_sys) begin
        if (accept) begin
            reg_addr <= haddr & ~(`APU_WINDOW_MASK | 16'h0003);
        end
    end

    // ----------------------------------------------------------------------
    // Data phase

    assign aout_wen  = aout_sel && dphase_write;
    assign timer_wen = timer_sel && dphase_write;

    // Unmapped space and write data phases return zero
    always_comb begin
        hrdata = '0;
        if (!dphase_write) begin
            if (aout_sel) begin
                hrdata = aout_rdata;
            end else if (timer_sel) begin
                hrdata = timer_rdata;
            end
        end
    end

endmodule

/* src/apu_audio_top.sv */
// APU audio output block
// AHB-Lite slave port with the AOUT PWM peripheral and the compare timer

module apu_audio_top import apu_pkg::*; (
    input  logic      clk_sys,
    input  logic      rst_n_sram,

    input  bus_addr_t haddr,
    input  logic      hwrite,
    input  htrans_t   htrans,
    input  bus_word_t hwdata,
    input  logic      hready,
    output bus_word_t hrdata,

    output logic      audio,
    output logic      irq_apu_aout,
    output logic      irq_apu_timer
);

    bus_addr_t reg_addr;
    logic      aout_wen;
    logic      timer_wen;
    bus_word_t aout_rdata;
    bus_word_t timer_rdata;

    // ----------------------------------------------------------------------
    // Bus port

    apu_ahbl_port port_u (
        .clk_sys     (clk_sys),
        .rst_n_sram  (rst_n_sram),
        .haddr       (haddr),
        .hwrite      (hwrite),
        .htrans      (htrans),
        .hready      (hready),
        .hrdata      (hrdata),
        .reg_addr    (reg_addr),
        .aout_wen    (aout_wen),
        .timer_wen   (timer_wen),
        .aout_rdata  (aout_rdata),
        .timer_rdata (timer_rdata)
    );

    // ----------------------------------------------------------------------
    // Peripherals

    // Write data is valid in the data phase and goes straight through
    apu_aout aout_u (
        .clk_sys    (clk_sys),
        .rst_n_sram (rst_n_sram),
        .reg_addr   (reg_addr),
        .wen        (aout_wen),
        .wdata      (hwdata),
        .rdata      (aout_rdata),
        .audio      (audio),
        .irq        (irq_apu_aout)
    );

    apu_timer timer_u (
        .clk_sys    (clk_sys),
        .rst_n_sram (rst_n_sram),
        .reg_addr   (reg_addr),
        .wen        (timer_wen),
        .wdata      (hwdata),
        .rdata      (timer_rdata),
        .irq        (irq_apu_timer)
    );

endmodule

/* tests/tb_apu_tasks.svh */
// APU audio testbench tasks
// AHB-Lite driver, typed compares and the directed tests

`ifndef TB_APU_TASKS_SVH
`define TB_APU_TASKS_SVH

localparam bus_addr_t AOUT_CSR   = `APU_AOUT_BASE | `APU_AOUT_CSR;
localparam bus_addr_t AOUT_FIFO  = `APU_AOUT_BASE | `APU_AOUT_FIFO;
localparam bus_addr_t TIMER_CTRL = `APU_TIMER_BASE | `APU_TIMER_CTRL;
localparam bus_addr_t TIMER_CNT  = `APU_TIMER_BASE | `APU_TIMER_COUNT;
localparam bus_addr_t TIMER_CMP  = `APU_TIMER_BASE | `APU_TIMER_CMP;

// Writable CSR fields apart from ENABLE
localparam bus_word_t CSR_RW_MASK = (32'h1 << `APU_CSR_SIGNED_BIT)
                                  | (32'h7 << `APU_CSR_IRQLEVEL_LSB)
                                  | (32'hff << `APU_CSR_INTERVAL_LSB);
localparam bus_word_t CSR_RDY     = 32'h1 << `APU_CSR_RDY_BIT;
localparam bus_word_t CSR_ENABLE  = 32'h1 << `APU_CSR_ENABLE_BIT;
localparam bus_word_t CSR_SIGNED  = 32'h1 << `APU_CSR_SIGNED_BIT;
localparam bus_word_t CSR_RUNNING = 32'h1 << `APU_CSR_RUNNING_BIT;

// ----------------------------------------------------------------------
// Bus driver and reset

task automatic apply_reset();
    @(posedge clk_sys);
    rst_n_sram <= 1'b0;
    repeat (4) @(posedge clk_sys);
    rst_n_sram <= 1'b1;
endtask

// Returns on the edge that ends the data phase
task automatic ahb_write(input bus_addr_t addr, input bus_word_t data);
    @(posedge clk_sys);
    haddr  <= addr;
    hwrite <= 1'b1;
    htrans <= 2'b10;
    @(posedge clk_sys);
    htrans <= 2'b00;
    hwrite <= 1'b0;
    hwdata <= data;
    @(posedge clk_sys);
endtask

// Samples hrdata in the middle of the data phase
task automatic ahb_read(input bus_addr_t addr, output bus_word_t data);
    @(posedge clk_sys);
    haddr  <= addr;
    hwrite <= 1'b0;
    htrans <= 2'b10;
    @(posedge clk_sys);
    htrans <= 2'b00;
    @(negedge clk_sys);
    data = hrdata;
endtask

// ----------------------------------------------------------------------
// Compares

task automatic check_word(input string name, input bus_word_t got, input bus_word_t exp);
    if (got !== exp) begin
        $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
        err_value++;
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
        err_value++;
    end
endtask

task automatic check_duty(input string name, input pwm_duty_t got, input pwm_duty_t exp);
    if (got !== exp) begin
        $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
        err_value++;
    end
endtask

// High time of audio from its next rising edge, in clk_sys cycles
task automatic measure_duty(output pwm_duty_t duty);
    int waited;
    int high_cycles;
    waited      = 0;
    high_cycles = 0;
    duty        = '0;
    @(negedge clk_sys);
    while (audio !== 1'b0 && waited < 2 * PWM_PERIOD) begin
        @(negedge clk_sys);
        waited++;
    end
    while (audio !== 1'b1 && waited < 2 * PWM_PERIOD) begin
        @(negedge clk_sys);
        waited++;
    end
    if (waited >= 2 * PWM_PERIOD) begin
        $display("audio showed no rising edge within %0d cycles", 2 * PWM_PERIOD);
        err_other++;
    end else begin
        while (audio === 1'b1 && high_cycles < PWM_PERIOD) begin
            high_cycles++;
            @(negedge clk_sys);
        end
        duty = pwm_duty_t'(high_cycles);
    end
endtask

// ----------------------------------------------------------------------
// Directed tests

task automatic register_readback();
    bus_word_t rd;
    bus_word_t rnd;
    rnd = $random(seed);
    ahb_read(AOUT_CSR, rd);
    // ENABLE, RUNNING and FLEVEL clear, RDY set
    check_word("AOUT CSR after reset", rd, CSR_RDY);
    check_bit("irq_apu_aout after reset", irq_apu_aout, 1'b1);
    check_bit("irq_apu_timer after reset", irq_apu_timer, 1'b0);
    ahb_write(AOUT_CSR, rnd & ~CSR_ENABLE);
    ahb_read(AOUT_CSR, rd);
    check_word("AOUT CSR readback", rd, (rnd & CSR_RW_MASK) | CSR_RDY);
    rnd = $random(seed);
    ahb_write(TIMER_CMP, rnd);
    ahb_read(TIMER_CMP, rd);
    check_word("timer CMP readback", rd, rnd);
    rnd = $random(seed);
    ahb_write(TIMER_CNT, rnd);
    ahb_read(TIMER_CNT, rd);
    check_word("timer COUNT readback", rd, rnd);
    ahb_write(16'hc000, $random(seed));
    ahb_read(16'hc000, rd);
    check_word("unmapped read 0xc000", rd, '0);
    ahb_read(`APU_AOUT_BASE | 16'h000c, rd);
    check_word("unused AOUT offset", rd, '0);
endtask

task automatic fifo_level_irq();
    bus_word_t rd;
    bus_word_t rnd;
    int        exp_level;
    int        n;
    logic [2:0] irq_level;
    apply_reset();
    rnd       = $random(seed);
    irq_level = {1'b0, rnd[1:0]};
    ahb_write(AOUT_CSR, bus_word_t'(irq_level) << `APU_CSR_IRQLEVEL_LSB);
    for (n = 1; n <= 5; n++) begin
        ahb_write(AOUT_FIFO, $random(seed));
        exp_level = (n > 4) ? 4 : n;
        @(negedge clk_sys);
        check_bit("irq_apu_aout", irq_apu_aout, exp_level <= int'(irq_level));
        ahb_read(AOUT_CSR, rd);
        check_word("FLEVEL", bus_word_t'(rd[`APU_CSR_FLEVEL_MSB:`APU_CSR_FLEVEL_LSB]),
                   bus_word_t'(exp_level));
        check_bit("RDY", rd[`APU_CSR_RDY_BIT], exp_level < 4);
    end
endtask

task automatic pwm_duty_sign();
    pwm_duty_t got;
    apply_reset();
    // Unsigned 0x4000 plays its top byte as is
    ahb_write(AOUT_FIFO, 32'h0000_4000);
    ahb_write(AOUT_CSR, CSR_SIGNED);
    // Signed 0x4000 sits above midscale
    ahb_write(AOUT_FIFO, 32'h0000_4000);
    ahb_write(AOUT_CSR, CSR_SIGNED | CSR_ENABLE);
    measure_duty(got);
    check_duty("audio duty, unsigned sample", got, 8'h40);
    measure_duty(got);
    check_duty("audio duty, signed sample", got, 8'hc0);
endtask

task automatic repeat_and_drain();
    pwm_duty_t exp_duty [3];
    pwm_duty_t got;
    sample_t   smp;
    bus_word_t rnd;
    bus_word_t rd;
    bus_word_t csr_val;
    int        i;
    int        p;
    int        start;
    logic      audio_seen;
    apply_reset();
    csr_val = (32'd2 << `APU_CSR_INTERVAL_LSB) | CSR_SIGNED;
    ahb_write(AOUT_CSR, csr_val);
    // Duties kept mid-range so a CSR read fits between periods
    for (i = 0; i < 3; i++) begin
        rnd         = $random(seed);
        exp_duty[i] = 8'h20 + {1'b0, rnd[6:0]};
        smp         = {exp_duty[i] ^ 8'h80, rnd[15:8]};
        ahb_write(AOUT_FIFO, bus_word_t'(smp));
    end
    ahb_write(AOUT_CSR, csr_val | CSR_ENABLE);
    for (i = 0; i < 3; i++) begin
        for (p = 0; p < 3; p++) begin
            measure_duty(got);
            check_duty($sformatf("audio duty, sample %0d period %0d", i, p), got, exp_duty[i]);
            if (p == 1) begin
                ahb_read(AOUT_CSR, rd);
                check_word($sformatf("AOUT CSR while playing sample %0d", i), rd,
                           csr_val | CSR_ENABLE | CSR_RUNNING | CSR_RDY
                           | (bus_word_t'(2 - i) << `APU_CSR_FLEVEL_LSB));
            end
        end
    end
    ahb_write(AOUT_CSR, csr_val);
    start = cycle_count;
    do begin
        ahb_read(AOUT_CSR, rd);
    end while (rd[`APU_CSR_RUNNING_BIT] !== 1'b0 && cycle_count - start < PWM_PERIOD + 8);
    check_bit("RUNNING after disable", rd[`APU_CSR_RUNNING_BIT], 1'b0);
    audio_seen = 1'b0;
    repeat (PWM_PERIOD + 44) begin
        @(negedge clk_sys);
        audio_seen = audio_seen | (audio !== 1'b0);
    end
    check_bit("audio after stop", audio_seen, 1'b0);
endtask

task automatic timer_compare();
    bus_word_t cnt;
    bus_word_t rnd;
    int        reads;
    apply_reset();
    ahb_write(TIMER_CNT, 32'd0);
    ahb_write(TIMER_CMP, 32'd200);
    ahb_write(TIMER_CTRL, 32'd1);
    ahb_read(TIMER_CTRL, cnt);
    check_word("timer CTRL readback", cnt, 32'd1);
    reads = 0;
    do begin
        ahb_read(TIMER_CNT, cnt);
        check_bit($sformatf("irq_apu_timer at count %0d", cnt), irq_apu_timer, cnt >= 200);
        reads++;
    end while (cnt < 200 && reads < 400);
    if (cnt < 200) begin
        $display("Timer count never reached the compare value");
        err_other++;
    end
    ahb_write(TIMER_CTRL, 32'd0);
    @(negedge clk_sys);
    check_bit("irq_apu_timer after disable", irq_apu_timer, 1'b0);
    ahb_read(TIMER_CTRL, cnt);
    check_word("timer CTRL after disable", cnt, '0);
    rnd = $random(seed);
    ahb_write(TIMER_CNT, rnd);
    ahb_read(TIMER_CNT, cnt);
    check_word("timer COUNT while disabled", cnt, rnd);
    check_bit("irq_apu_timer while disabled", irq_apu_timer, 1'b0);
endtask

`endif

/* tests/tb_apu_audio.sv */
// APU audio block testbench
// Clock, reset, DUT and the directed test sequence

`include "apu_consts.svh"

module tb_apu_audio import apu_pkg::*; ();

    // Longest test is about 12 PWM periods and the limit leaves several times the total
    localparam int PWM_PERIOD     = 1 << `APU_PWM_BITS;
    localparam int TIMEOUT_CYCLES = 20000;

    logic      clk_sys = 1'b0;
    logic      rst_n_sram;
    bus_addr_t haddr;
    logic      hwrite;
    htrans_t   htrans;
    bus_word_t hwdata;
    logic      hready;
    bus_word_t hrdata;
    logic      audio;
    logic      irq_apu_aout;
    logic      irq_apu_timer;

    integer seed = 32'h0f25_3ecd;
    int     err_value = 0;
    int     err_other = 0;
    int     cycle_count = 0;

    always #50 clk_sys = ~clk_sys;

    apu_audio_top UUT (
        .clk_sys       (clk_sys),
        .rst_n_sram    (rst_n_sram),
        .haddr         (haddr),
        .hwrite        (hwrite),
        .htrans        (htrans),
        .hwdata        (hwdata),
        .hready        (hready),
        .hrdata        (hrdata),
        .audio         (audio),
        .irq_apu_aout  (irq_apu_aout),
        .irq_apu_timer (irq_apu_timer)
    );

    `include "tb_apu_tasks.svh"

    // ----------------------------------------------------------------------
    // Run limit

    always @(posedge clk_sys) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("Timeout: run stopped after %0d cycles", TIMEOUT_CYCLES);
            $display("Checks failed");
            $finish;
        end
    end

    // ----------------------------------------------------------------------
    // Test sequence

    initial begin
        rst_n_sram <= 1'b0;
        haddr      <= '0;
        hwrite     <= 1'b0;
        htrans     <= 2'b00;
        hwdata     <= '0;
        hready     <= 1'b1;

        apply_reset();
        register_readback();
        fifo_level_irq();
        pwm_duty_sign();
        repeat_and_drain();
        timer_compare();

        $display("Errors: %0d wrong values, %0d other failures", err_value, err_other);
        if (err_value + err_other == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* build.f */
+incdir+src
+incdir+tests
src/apu_pkg.sv
src/apu_sample_fifo.sv
src/apu_pwm_out.sv
src/apu_aout.sv
src/apu_timer.sv
src/apu_ahbl_port.sv
src/apu_audio_top.sv
tests/tb_apu_audio.sv

/* Makefile */
SIM       = verilator
FLAGS     = --binary --timing -j 0
TOP       = tb_apu_audio
FILELIST  = build.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = All checks passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
